//--- hdl/fetch_params.svh
// Queue depth must be at least the burst length or no fetch can ever start
`ifndef FETCH_PARAMS_SVH
`define FETCH_PARAMS_SVH

// --------------------
// Prefetch queue
// --------------------

// Entries held in the prefetch queue
`define FETCH_QUEUE_DEPTH 8

// --------------------
// Memory side
// --------------------

// Words read per burst
`define FETCH_BURST_WORDS 4

// Byte address width
`define FETCH_ADDR_W 32

`endif

//--- hdl/fetch_pkg.sv
// Entry count holds 1 to 4 and the lowest addressed byte sits in bits 7:0
`default_nettype none

package fetch_pkg;

    // Fetch controller state
    typedef enum logic {
        FETCH_IDLE = 1'b0,
        FETCH_READ = 1'b1
    } fetch_state_e;

    // Burst reader handshake state
    // RD_REQ holds req high until ack
    // RD_RELEASE holds req low until ack drops
    typedef enum logic [1:0] {
        RD_IDLE    = 2'd0,
        RD_REQ     = 2'd1,
        RD_RELEASE = 2'd2
    } reader_state_e;

    // One queue entry, up to four bytes of code
    typedef struct packed {
        logic [2:0]  count;
        logic [31:0] bytes;
    } prefetch_entry_t;

endpackage

`default_nettype wire

//--- hdl/code_bus_if.sv
// Start is honoured only while the reader is idle and address is sampled with start only
`default_nettype none
`include "fetch_params.svh"

interface code_bus_if;

    // Burst request from the fetch controller
    logic                     start;
    logic [`FETCH_ADDR_W-1:0] address;

    // Word return from the burst reader
    logic [31:0]              word;
    logic                     partial_done;
    logic                     done;

    modport fetcher (
        output start,
        output address,
        input  word,
        input  partial_done,
        input  done
    );

    modport reader (
        input  start,
        input  address,
        output word,
        output partial_done,
        output done
    );

endinterface

`default_nettype wire

//--- hdl/line_fetch.sv
// Caller limits fetch_length to 16 and to page and segment bounds before the request
`default_nettype none
`include "fetch_params.svh"

module line_fetch (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       flush,
    input  logic                       fetch_do,
    input  logic [`FETCH_ADDR_W-1:0]   fetch_address,
    input  logic [4:0]                 fetch_length,
    output logic                       fetch_idle,
    code_bus_if.fetcher                bus,
    input  logic                       line_room,
    output logic                       entry_write,
    output fetch_pkg::prefetch_entry_t entry,
    output logic                       prefetched_do,
    output logic [4:0]                 prefetched_length
);

    // Three bits of byte count per burst word
    localparam int CNT_W = 3 * `FETCH_BURST_WORDS;

    // --------------------
    // State
    // --------------------

    fetch_pkg::fetch_state_e state;
    logic [1:0]              offset;
    logic [4:0]              remaining;
    logic [CNT_W-1:0]        count_list;
    logic                    flush_pending;

    logic [CNT_W-1:0]        count_init;
    logic                    accept;
    logic                    word_in;
    logic [2:0]              word_count;
    logic [2:0]              take_count;
    logic                    deliver;

    // Per-word counts at acceptance
    // First word loses the bytes below the start offset
    always_comb begin
        count_init = '0;
        for (int i = 0; i < `FETCH_BURST_WORDS; i++) begin
            count_init[3*i +: 3] = 3'd4;
        end
        count_init[2:0] = 3'd4 - {1'b0, fetch_address[1:0]};
    end

    // --------------------
    // Request side
    // --------------------

    // New burst only with room for every word of it
    assign accept = (state == fetch_pkg::FETCH_IDLE) && fetch_do && (fetch_length != 5'd0)
                    && !flush && line_room;

    assign bus.start   = accept;
    assign bus.address = {fetch_address[`FETCH_ADDR_W-1:2], 2'b00};
    assign fetch_idle  = (state == fetch_pkg::FETCH_IDLE);

    // --------------------
    // Word trimming
    // --------------------

    assign word_in    = bus.partial_done || bus.done;
    assign word_count = count_list[2:0];

    // Smaller of word count and bytes still wanted
    assign take_count = ({2'b00, word_count} > remaining) ? remaining[2:0] : word_count;

    // Nothing reaches the queue once a flush has been seen
    assign deliver = (state == fetch_pkg::FETCH_READ) && word_in && !flush && !flush_pending
                     && (remaining != 5'd0);

    assign entry_write       = deliver;
    assign entry             = '{count: take_count, bytes: bus.word >> {offset, 3'b000}};
    assign prefetched_do     = deliver;
    assign prefetched_length = {2'b00, take_count};

    // Back to idle on the edge after the last word
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= fetch_pkg::FETCH_IDLE;
        end else if (accept) begin
            state <= fetch_pkg::FETCH_READ;
        end else if ((state == fetch_pkg::FETCH_READ) && bus.done) begin
            state <= fetch_pkg::FETCH_IDLE;
        end
    end

    // Flush mid-burst mutes the rest of that burst
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            flush_pending <= 1'b0;
        end else if ((state == fetch_pkg::FETCH_READ) && flush) begin
            flush_pending <= 1'b1;
        end else if (state == fetch_pkg::FETCH_IDLE) begin
            flush_pending <= 1'b0;
        end
    end

    // Offset only applies to word 0 so it clears after the first return
    always_ff @(posedge clk) begin
        if (accept) begin
            offset     <= fetch_address[1:0];
            remaining  <= fetch_length;
            count_list <= count_init;
        end else if ((state == fetch_pkg::FETCH_READ) && word_in) begin
            offset     <= 2'b00;
            count_list <= count_list >> 3;
            if (deliver) begin
                remaining <= remaining - {2'b00, take_count};
            end
        end
    end

endmodule

`default_nettype wire

//--- hdl/burst_reader.sv
// Always finishes all words of a burst and waits for ack low before each new req
`default_nettype none
`include "fetch_params.svh"

module burst_reader (
    input  logic                     clk,
    input  logic                     rst_n,
    code_bus_if.reader               bus,
    output logic                     mem_req,
    output logic [`FETCH_ADDR_W-1:0] mem_addr,
    input  logic                     mem_ack,
    input  logic [31:0]              mem_rdata
);

    localparam int WCNT_W = $clog2(`FETCH_BURST_WORDS);
    localparam logic [WCNT_W-1:0] LAST_WORD = WCNT_W'(`FETCH_BURST_WORDS - 1);
    localparam logic [`FETCH_ADDR_W-1:0] WORD_STEP = 4;

    fetch_pkg::reader_state_e state;
    logic [WCNT_W-1:0]        word_cnt;
    logic [`FETCH_ADDR_W-1:0] addr;
    logic [31:0]              data_q;
    logic                     partial_q;
    logic                     done_q;
    logic                     capture;
    logic                     last_word;

    // Ack seen while requesting
    assign capture   = (state == fetch_pkg::RD_REQ) && mem_ack;
    assign last_word = (word_cnt == LAST_WORD);

    // --------------------
    // Handshake FSM
    // --------------------

    // Burst enters through RD_RELEASE so a late ack from the last burst drains first
    // Final word goes straight to idle so the next start is never missed
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state     <= fetch_pkg::RD_IDLE;
            word_cnt  <= '0;
            partial_q <= 1'b0;
            done_q    <= 1'b0;
        end else begin
            // Pulse one cycle after the capture edge
            partial_q <= capture && !last_word;
            done_q    <= capture && last_word;
            case (state)
                fetch_pkg::RD_IDLE: begin
                    if (bus.start) begin
                        state    <= fetch_pkg::RD_RELEASE;
                        word_cnt <= '0;
                    end
                end
                fetch_pkg::RD_RELEASE: begin
                    if (!mem_ack) begin
                        state <= fetch_pkg::RD_REQ;
                    end
                end
                fetch_pkg::RD_REQ: begin
                    if (mem_ack) begin
                        word_cnt <= word_cnt + 1'b1;
                        state    <= last_word ? fetch_pkg::RD_IDLE : fetch_pkg::RD_RELEASE;
                    end
                end
                default: begin
                    state <= fetch_pkg::RD_IDLE;
                end
            endcase
        end
    end

    // Address steps once req is down
    always_ff @(posedge clk) begin
        if ((state == fetch_pkg::RD_IDLE) && bus.start) begin
            addr <= bus.address;
        end else if (capture) begin
            addr <= addr + WORD_STEP;
        end
        if (capture) begin
            data_q <= mem_rdata;
        end
    end

    assign mem_req          = (state == fetch_pkg::RD_REQ);
    assign mem_addr         = addr;
    assign bus.word         = data_q;
    assign bus.partial_done = partial_q;
    assign bus.done         = done_q;

endmodule

`default_nettype wire

//--- hdl/prefetch_queue.sv
// Writer must respect line_room because a write into a full queue is not blocked
`default_nettype none
`include "fetch_params.svh"

module prefetch_queue (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       flush,
    input  logic                       entry_write,
    input  fetch_pkg::prefetch_entry_t entry,
    output logic                       line_room,
    output logic                       byte_valid,
    output logic [7:0]                 byte_data,
    input  logic                       byte_take
);

    localparam int DEPTH = `FETCH_QUEUE_DEPTH;
    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = $clog2(DEPTH + 1);

    fetch_pkg::prefetch_entry_t mem [DEPTH];
    fetch_pkg::prefetch_entry_t head;
    logic [PTR_W-1:0]           wr_ptr;
    logic [PTR_W-1:0]           rd_ptr;
    logic [CNT_W-1:0]           used;
    logic [1:0]                 byte_idx;
    logic                       take;
    logic                       head_last;
    logic                       pop;

    // Wrap for any depth
    function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] p);
        return (p == PTR_W'(DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    // --------------------
    // Byte output
    // --------------------

    assign head       = mem[rd_ptr];
    assign byte_valid = (used != '0);
    assign byte_data  = head.bytes[{byte_idx, 3'b000} +: 8];
    assign take       = byte_valid && byte_take;
    assign head_last  = ({1'b0, byte_idx} == (head.count - 3'd1));
    assign pop        = take && head_last;

    // Room for a whole burst of entries
    assign line_room = (DEPTH - int'(used)) >= `FETCH_BURST_WORDS;

    // Flush drops everything on the sampling edge
    always_ff @(posedge clk) begin
        if (!rst_n || flush) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            used     <= '0;
            byte_idx <= '0;
        end else begin
            if (entry_write) begin
                wr_ptr <= ptr_next(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= ptr_next(rd_ptr);
            end
            if (entry_write && !pop) begin
                used <= used + 1'b1;
            end else if (pop && !entry_write) begin
                used <= used - 1'b1;
            end
            // Byte index restarts with each new head
            if (pop) begin
                byte_idx <= '0;
            end else if (take) begin
                byte_idx <= byte_idx + 1'b1;
            end
        end
    end

    // Entry storage
    always_ff @(posedge clk) begin
        if (entry_write) begin
            mem[wr_ptr] <= entry;
        end
    end

endmodule

`default_nettype wire

//--- hdl/fetch_top.sv
// Every fetch reads a full burst from memory since there is no cache behind this path
`default_nettype none
`include "fetch_params.svh"

module fetch_top (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     flush,
    input  logic                     fetch_do,
    input  logic [`FETCH_ADDR_W-1:0] fetch_address,
    input  logic [4:0]               fetch_length,
    output logic                     fetch_idle,
    output logic                     prefetched_do,
    output logic [4:0]               prefetched_length,
    output logic                     mem_req,
    output logic [`FETCH_ADDR_W-1:0] mem_addr,
    input  logic                     mem_ack,
    input  logic [31:0]              mem_rdata,
    output logic                     byte_valid,
    output logic [7:0]               byte_data,
    input  logic                     byte_take
);

    // Controller to reader burst bus
    code_bus_if bus ();

    // Controller to queue
    logic                       line_room;
    logic                       entry_write;
    fetch_pkg::prefetch_entry_t entry;

    line_fetch u_line_fetch (
        .clk               (clk),
        .rst_n             (rst_n),
        .flush             (flush),
        .fetch_do          (fetch_do),
        .fetch_address     (fetch_address),
        .fetch_length      (fetch_length),
        .fetch_idle        (fetch_idle),
        .bus               (bus.fetcher),
        .line_room         (line_room),
        .entry_write       (entry_write),
        .entry             (entry),
        .prefetched_do     (prefetched_do),
        .prefetched_length (prefetched_length)
    );

    burst_reader u_burst_reader (
        .clk       (clk),
        .rst_n     (rst_n),
        .bus       (bus.reader),
        .mem_req   (mem_req),
        .mem_addr  (mem_addr),
        .mem_ack   (mem_ack),
        .mem_rdata (mem_rdata)
    );

    prefetch_queue u_prefetch_queue (
        .clk         (clk),
        .rst_n       (rst_n),
        .flush       (flush),
        .entry_write (entry_write),
        .entry       (entry),
        .line_room   (line_room),
        .byte_valid  (byte_valid),
        .byte_data   (byte_data),
        .byte_take   (byte_take)
    );

endmodule

`default_nettype wire

//--- bench/fetch_properties.sv
// Bound into fetch_top and reads the queue fill level through the queue instance
`default_nettype none
`include "fetch_params.svh"

module fetch_properties (
    input logic                                     clk,
    input logic                                     rst_n,
    input logic                                     mem_req,
    input logic                                     mem_ack,
    input logic                                     prefetched_do,
    input logic [4:0]                               prefetched_length,
    input logic                                     entry_write,
    input logic [$clog2(`FETCH_QUEUE_DEPTH+1)-1:0]  queue_used
);

    timeunit 1ns;
    timeprecision 100ps;

    // --------------------
    // Memory handshake
    // --------------------

    // Req held until ack is seen
    a_req_held: assert property (@(posedge clk) disable iff (!rst_n)
        (mem_req && !mem_ack) |=> mem_req)
        else $error("mem_req dropped before mem_ack");

    // Ack only answers a live request
    a_ack_needs_req: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(mem_ack) |-> mem_req)
        else $error("mem_ack rose without mem_req");

    // --------------------
    // Queue side
    // --------------------

    a_len_range: assert property (@(posedge clk) disable iff (!rst_n)
        prefetched_do |-> (prefetched_length >= 5'd1 && prefetched_length <= 5'd4))
        else $error("prefetched_length out of range");

    a_no_overflow: assert property (@(posedge clk) disable iff (!rst_n)
        entry_write |-> (int'(queue_used) < `FETCH_QUEUE_DEPTH))
        else $error("entry written into a full queue");

endmodule

bind fetch_top fetch_properties u_fetch_properties (
    .clk               (clk),
    .rst_n             (rst_n),
    .mem_req           (mem_req),
    .mem_ack           (mem_ack),
    .prefetched_do     (prefetched_do),
    .prefetched_length (prefetched_length),
    .entry_write       (entry_write),
    .queue_used        (u_prefetch_queue.used)
);

`default_nettype wire

//--- bench/fetch_tb.sv
// Memory is a hash of the word address and every fetch is expected to run a full burst
`default_nettype none
`include "fetch_params.svh"

module fetch_tb;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int CLK_PERIOD       = 4;
    localparam int FETCHES_PER_TEST = 20;
    localparam int NUM_TESTS        = 6;
    localparam int CYCLES_PER_FETCH = 200;

    logic                     clk;
    logic                     rst_n;
    logic                     flush;
    logic                     fetch_do;
    logic [`FETCH_ADDR_W-1:0] fetch_address;
    logic [4:0]               fetch_length;
    logic                     fetch_idle;
    logic                     prefetched_do;
    logic [4:0]               prefetched_length;
    logic                     mem_req;
    logic [`FETCH_ADDR_W-1:0] mem_addr;
    logic                     mem_ack;
    logic [31:0]              mem_rdata;
    logic                     byte_valid;
    logic [7:0]               byte_data;
    logic                     byte_take;

    // Model state
    logic [31:0] lfsr = 32'h7f7773a9;
    logic [7:0]  exp_q [$];
    logic [7:0]  want;
    logic        flush_seen = 1'b0;
    int          reported_sum = 0;
    int          errors = 0;
    int          tests_failed = 0;
    int          take_level = 12;

    fetch_top dut (
        .clk (clk), .rst_n (rst_n), .flush (flush),
        .fetch_do (fetch_do), .fetch_address (fetch_address), .fetch_length (fetch_length),
        .fetch_idle (fetch_idle), .prefetched_do (prefetched_do),
        .prefetched_length (prefetched_length),
        .mem_req (mem_req), .mem_addr (mem_addr), .mem_ack (mem_ack), .mem_rdata (mem_rdata),
        .byte_valid (byte_valid), .byte_data (byte_data), .byte_take (byte_take)
    );

    // --------------------
    // Helpers
    // --------------------

    // Galois LFSR stepped once per bit
    function logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
            v = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    // Fixed hash of the word address
    function automatic logic [31:0] mem_word(input logic [31:0] a);
        logic [31:0] h;
        h = {a[31:2], 2'b00} * 32'h9e37_79b1;
        return h ^ (h >> 15) ^ 32'h5a5a_c3c3;
    endfunction

    // Byte A sits at bit 8*(A mod 4) of its word
    function automatic logic [7:0] mem_byte(input logic [31:0] a);
        logic [31:0] w;
        w = mem_word(a);
        return w[{a[1:0], 3'b000} +: 8];
    endfunction

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #((16 + CYCLES_PER_FETCH * FETCHES_PER_TEST * NUM_TESTS) * CLK_PERIOD);
        $display("TIMEOUT at %0t: the tests did not finish in the cycle budget", $time);
        $display("STATUS: FAIL");
        $finish;
    end

    // Four-phase memory responder with random stalls
    initial begin
        mem_ack   = 1'b0;
        mem_rdata = '0;
        wait (rst_n === 1'b1);
        forever begin
            do @(posedge clk); while (!mem_req);
            repeat (rand_bits(3) % 6) @(posedge clk);
            mem_ack   <= 1'b1;
            mem_rdata <= mem_word(mem_addr);
            do @(posedge clk); while (mem_req);
            repeat (rand_bits(3) % 6) @(posedge clk);
            mem_ack   <= 1'b0;
        end
    end

    // Decoder takes a byte when a 4-bit draw is under take_level
    initial begin
        byte_take = 1'b0;
        forever begin
            @(posedge clk);
            byte_take <= (rand_bits(4) < take_level);
        end
    end

    // Byte stream check and flush tracking
    always @(posedge clk) begin
        if (rst_n) begin
            if (flush_seen && byte_valid) begin
                errors++;
                $display("ERROR at %0t: byte_valid still high after flush", $time);
            end
            flush_seen = flush;
            if (byte_valid && byte_take) begin
                if (exp_q.size() == 0) begin
                    errors++;
                    $display("ERROR at %0t: extra byte %h with none expected", $time, byte_data);
                end else begin
                    want = exp_q.pop_front();
                    if (byte_data !== want) begin
                        errors++;
                        $display("MISMATCH at %0t: byte %h, expected %h", $time, byte_data, want);
                    end
                end
            end
            if (flush) begin
                exp_q.delete();
            end
            if (prefetched_do) begin
                reported_sum += prefetched_length;
            end
        end
    end

    // --------------------
    // Tasks
    // --------------------

    task automatic run_fetch(input logic [31:0] addr, input logic [4:0] len, input logic cut);
        int expect_n;
        expect_n = (int'(len) < 16 - int'(addr[1:0])) ? int'(len) : 16 - int'(addr[1:0]);
        @(posedge clk);
        fetch_address <= addr;
        fetch_length  <= len;
        fetch_do      <= 1'b1;
        if (len == 5'd0) begin
            repeat (8) begin
                @(posedge clk);
                if (mem_req || !fetch_idle) begin
                    errors++;
                    $display("ERROR at %0t: zero-length fetch started a burst", $time);
                end
            end
            fetch_do <= 1'b0;
        end else begin
            // Accepted once the controller leaves idle
            do @(posedge clk); while (fetch_idle);
            fetch_do     <= 1'b0;
            reported_sum = 0;
            for (int i = 0; i < expect_n; i++) begin
                exp_q.push_back(mem_byte(addr + i));
            end
            if (cut) begin
                repeat (1 + rand_bits(2)) @(posedge clk);
                flush <= 1'b1;
                @(posedge clk);
                flush <= 1'b0;
            end
            do @(posedge clk); while (!fetch_idle);
            if (!cut && reported_sum != expect_n) begin
                errors++;
                $display("MISMATCH at %0t: fetch %h len %0d gave %0d bytes, expected %0d",
                         $time, addr, len, reported_sum, expect_n);
            end
        end
    endtask

    task automatic drain_queue();
        take_level = 16;
        do @(posedge clk); while (byte_valid);
        if (exp_q.size() != 0) begin
            errors++;
            $display("ERROR at %0t: %0d expected bytes never arrived", $time, exp_q.size());
            exp_q.delete();
        end
    endtask

    // Mode selects aligned, misaligned, short, back-pressure, flush or zero length
    task automatic run_test(input string name, input int mode);
        int          errors_before;
        logic [31:0] addr;
        logic [4:0]  len;
        errors_before = errors;
        take_level    = (mode == 3) ? 3 : 12;
        for (int n = 0; n < FETCHES_PER_TEST; n++) begin
            addr = rand_bits(32);
            len  = 5'd16;
            case (mode)
                0: addr[1:0] = 2'b00;
                1: addr[1:0] = 2'd1 + 2'(rand_bits(2) % 3);
                2: len = 5'd1 + 5'(rand_bits(4) % 15);
                3: len = 5'(rand_bits(5) % 17);
                4: len = 5'd1 + 5'(rand_bits(4));
                default: len = 5'd0;
            endcase
            // Flush mode cuts every other fetch so the next one shows recovery
            run_fetch(addr, len, (mode == 4) && (n % 2 == 0));
        end
        drain_queue();
        if (errors == errors_before) begin
            $display("test %-14s ok", name);
        end else begin
            tests_failed++;
            $display("test %-14s failed with %0d errors", name, errors - errors_before);
        end
    endtask

    initial begin
        rst_n         = 1'b0;
        flush         = 1'b0;
        fetch_do      = 1'b0;
        fetch_address = '0;
        fetch_length  = '0;
        repeat (16) @(posedge clk);
        rst_n <= 1'b1;
        run_test("aligned", 0);
        run_test("misaligned", 1);
        run_test("short", 2);
        run_test("backpressure", 3);
        run_test("flush", 4);
        run_test("zero_length", 5);
        $display("tests %0d, failed %0d, errors %0d", NUM_TESTS, tests_failed, errors);
        if (errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- compile.f
+incdir+hdl
hdl/fetch_pkg.sv
hdl/code_bus_if.sv
hdl/line_fetch.sv
hdl/burst_reader.sv
hdl/prefetch_queue.sv
hdl/fetch_top.sv
bench/fetch_properties.sv
bench/fetch_tb.sv

//--- Bender.yml
package:
  name: fetch_path

export_include_dirs:
  - hdl

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/fetch_pkg.sv
      - hdl/code_bus_if.sv
      - hdl/line_fetch.sv
      - hdl/burst_reader.sv
      - hdl/prefetch_queue.sv
      - hdl/fetch_top.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - bench/fetch_properties.sv
      - bench/fetch_tb.sv
